// ==== fpuPkg.sv ====
`default_nettype none
////////////////////
// fpu simple-ops package
// widths, opcodes, format codes, canonical NaNs and credit depths
////////////////////

package fpuPkg;

	////////////////////
	// operand widths
	////////////////////

	// register format is always the double width
	localparam int FLEN = 64;
	localparam int S_LEN = 32;
	localparam int D_LEN = 64;

	// exponent and fraction field widths per format
	localparam int S_EXP = 8;
	localparam int D_EXP = 11;
	localparam int S_FRAC = 23;
	localparam int D_FRAC = 52;

	// one bit is enough since only single and double exist here
	typedef enum logic {
		FMT_S = 1'b0,
		FMT_D = 1'b1
	} fmtT;

	// the three sign-injection codes come first so their low two bits
	// double as the injector's select
	typedef enum logic [3:0] {
		OP_FSGNJ  = 4'd0,
		OP_FSGNJN = 4'd1,
		OP_FSGNJX = 4'd2,
		OP_FMIN   = 4'd3,
		OP_FMAX   = 4'd4,
		OP_FEQ    = 4'd5,
		OP_FLT    = 4'd6,
		OP_FLE    = 4'd7,
		OP_FCLASS = 4'd8
	} fpuOpT;

	// canonical quiet NaN, positive sign and only the quiet bit set
	localparam logic [S_LEN-1:0] S_CANON_NAN = 32'h7fc0_0000;
	localparam logic [D_LEN-1:0] D_CANON_NAN = 64'h7ff8_0000_0000_0000;

	////////////////////
	// queue and classify
	////////////////////

	// queue entries, also the credits upstream holds after reset
	localparam int QUEUE_DEPTH = 2;
	// credits downstream has granted the queue after reset
	localparam int OUT_CREDITS = 4;
	localparam int CLASS_W = 10;

endpackage

`default_nettype wire

// ==== fpuUnpack.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// operand unpacker
// checks NaN-boxing and reports sign, exponent and fraction facts
////////////////////

module fpuUnpack (
	input  logic [fpuPkg::FLEN-1:0] val,
	input  fpuPkg::fmtT             fmt,
	output logic                    sgn,
	output logic                    expZero,
	output logic                    expMax,
	output logic                    fracZero,
	output logic                    quietBit,
	output logic [fpuPkg::FLEN-1:0] fixed
);

	logic                      boxOk;
	logic [fpuPkg::S_EXP-1:0]  sExp;
	logic [fpuPkg::S_FRAC-1:0] sFrac;
	logic [fpuPkg::D_EXP-1:0]  dExp;
	logic [fpuPkg::D_FRAC-1:0] dFrac;

	// a single is only valid when every bit above it is one
	assign boxOk = &val[fpuPkg::FLEN-1:fpuPkg::S_LEN];

	// a badly boxed single is replaced by the boxed canonical NaN so that
	// every later block sees a legal value
	assign fixed = (fmt == fpuPkg::FMT_S && !boxOk) ?
		{{(fpuPkg::FLEN-fpuPkg::S_LEN){1'b1}}, fpuPkg::S_CANON_NAN} : val;

	// field slices of the corrected value for both layouts
	assign sExp  = fixed[fpuPkg::S_LEN-2 -: fpuPkg::S_EXP];
	assign sFrac = fixed[fpuPkg::S_FRAC-1:0];
	assign dExp  = fixed[fpuPkg::D_LEN-2 -: fpuPkg::D_EXP];
	assign dFrac = fixed[fpuPkg::D_FRAC-1:0];

	// pick the facts of the selected format
	always_comb begin
		if (fmt == fpuPkg::FMT_D) begin
			sgn      = fixed[fpuPkg::D_LEN-1];
			expZero  = ~|dExp;
			expMax   = &dExp;
			fracZero = ~|dFrac;
			// top fraction bit tells quiet from signaling
			quietBit = dFrac[fpuPkg::D_FRAC-1];
		end else begin
			sgn      = fixed[fpuPkg::S_LEN-1];
			expZero  = ~|sExp;
			expMax   = &sExp;
			fracZero = ~|sFrac;
			quietBit = sFrac[fpuPkg::S_FRAC-1];
		end
	end

endmodule

`default_nettype wire

// ==== fpuSignInject.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// sign injection
// fsgnj, fsgnjn and fsgnjx with NaN-boxed single results
////////////////////

module fpuSignInject (
	input  logic                    xSgn,
	input  logic                    ySgn,
	input  logic [fpuPkg::FLEN-1:0] srcX,
	input  fpuPkg::fmtT             fmt,
	input  logic [1:0]              sgnOp,
	output logic [fpuPkg::FLEN-1:0] sgnRes
);

	logic resSgn;

	// sgnOp encoding
	//   00 takes Y's sign
	//   01 takes Y's sign inverted
	//   10 takes the XOR of both signs
	assign resSgn = sgnOp[1] ? (xSgn ^ ySgn) : (ySgn ^ sgnOp[0]);

	// magnitude always comes from X, only the sign bit is swapped
	// single results get ones above bit 31 to stay NaN-boxed
	always_comb begin
		if (fmt == fpuPkg::FMT_D) begin
			sgnRes = {resSgn, srcX[fpuPkg::D_LEN-2:0]};
		end else begin
			sgnRes = {{(fpuPkg::FLEN-fpuPkg::S_LEN){1'b1}}, resSgn,
				srcX[fpuPkg::S_LEN-2:0]};
		end
	end

endmodule

`default_nettype wire

// ==== fpuCompare.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// compare and min/max
// feq, flt, fle, fmin and fmax with RISC-V NaN rules and invalid flag
////////////////////

module fpuCompare (
	input  fpuPkg::fmtT             fmt,
	input  fpuPkg::fpuOpT           op,
	input  logic [fpuPkg::FLEN-1:0] srcX,
	input  logic [fpuPkg::FLEN-1:0] srcY,
	input  logic                    xSgn,
	input  logic                    xExpMax,
	input  logic                    xFracZero,
	input  logic                    xQuietBit,
	input  logic                    xExpZero,
	input  logic                    ySgn,
	input  logic                    yExpMax,
	input  logic                    yFracZero,
	input  logic                    yQuietBit,
	input  logic                    yExpZero,
	output logic [fpuPkg::FLEN-1:0] cmpRes,
	output logic                    invalid
);

	logic                      xNan, yNan, xSnan, ySnan, anyNan, anySnan;
	logic                      bothZero, magLt, magGt, magEq, xBelowY;
	logic                      eq, lt, le;
	logic [fpuPkg::FLEN-2:0]   magX, magY;
	logic [fpuPkg::FLEN-1:0]   canonNan, minRes, maxRes;

	// a signaling NaN has the quiet bit clear
	assign xNan    = xExpMax & ~xFracZero;
	assign yNan    = yExpMax & ~yFracZero;
	assign xSnan   = xNan & ~xQuietBit;
	assign ySnan   = yNan & ~yQuietBit;
	assign anyNan  = xNan | yNan;
	assign anySnan = xSnan | ySnan;

	// magnitudes drop the sign and singles are zero-extended
	assign magX = (fmt == fpuPkg::FMT_D) ? srcX[fpuPkg::D_LEN-2:0] :
		{{(fpuPkg::D_LEN-fpuPkg::S_LEN){1'b0}}, srcX[fpuPkg::S_LEN-2:0]};
	assign magY = (fmt == fpuPkg::FMT_D) ? srcY[fpuPkg::D_LEN-2:0] :
		{{(fpuPkg::D_LEN-fpuPkg::S_LEN){1'b0}}, srcY[fpuPkg::S_LEN-2:0]};
	assign magLt = magX < magY;
	assign magGt = magX > magY;
	assign magEq = magX == magY;
	assign bothZero = xExpZero & xFracZero & yExpZero & yFracZero;

	// min and max use a sign-magnitude ordering where -0 sits below +0
	assign xBelowY = (xSgn & ~ySgn) | (~xSgn & ~ySgn & magLt) | (xSgn & ySgn & magGt);

	// the compares treat the two zeros as equal and fail on any NaN
	assign eq = ~anyNan & (((xSgn == ySgn) & magEq) | bothZero);
	assign lt = ~anyNan & xBelowY & ~bothZero;
	assign le = lt | eq;

	// boxed canonical NaN for the selected format
	assign canonNan = (fmt == fpuPkg::FMT_D) ? fpuPkg::D_CANON_NAN :
		{{(fpuPkg::FLEN-fpuPkg::S_LEN){1'b1}}, fpuPkg::S_CANON_NAN};

	// a lone NaN loses to the other operand and two NaNs give the canonical one
	assign minRes = (xNan & yNan) ? canonNan : xNan ? srcY : yNan ? srcX :
		xBelowY ? srcX : srcY;
	assign maxRes = (xNan & yNan) ? canonNan : xNan ? srcY : yNan ? srcX :
		xBelowY ? srcY : srcX;

	always_comb begin
		cmpRes  = '0;
		invalid = 1'b0;
		case (op)
			fpuPkg::OP_FMIN: begin
				cmpRes  = minRes;
				invalid = anySnan;
			end
			fpuPkg::OP_FMAX: begin
				cmpRes  = maxRes;
				invalid = anySnan;
			end
			// feq is quiet and only signaling NaNs flag
			fpuPkg::OP_FEQ: begin
				cmpRes[0] = eq;
				invalid   = anySnan;
			end
			// the ordered compares flag on every NaN
			fpuPkg::OP_FLT: begin
				cmpRes[0] = lt;
				invalid   = anyNan;
			end
			fpuPkg::OP_FLE: begin
				cmpRes[0] = le;
				invalid   = anyNan;
			end
			default: begin
				cmpRes  = '0;
				invalid = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== fpuClassify.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// classify
// one-hot fclass mask from the unpacked facts of X
////////////////////

module fpuClassify (
	input  logic                       sgn,
	input  logic                       expZero,
	input  logic                       expMax,
	input  logic                       fracZero,
	input  logic                       quietBit,
	output logic [fpuPkg::CLASS_W-1:0] classMask
);

	logic isInf, isNan, isZero, isSub, isNorm;

	// exactly one of these is true for any bit pattern
	assign isInf  = expMax & fracZero;
	assign isNan  = expMax & ~fracZero;
	assign isZero = expZero & fracZero;
	assign isSub  = expZero & ~fracZero;
	assign isNorm = ~expZero & ~expMax;

	// bit order follows the RISC-V fclass table
	// NaNs ignore the sign
	assign classMask[0] = sgn & isInf;
	assign classMask[1] = sgn & isNorm;
	assign classMask[2] = sgn & isSub;
	assign classMask[3] = sgn & isZero;
	assign classMask[4] = ~sgn & isZero;
	assign classMask[5] = ~sgn & isSub;
	assign classMask[6] = ~sgn & isNorm;
	assign classMask[7] = ~sgn & isInf;
	// a clear quiet bit marks the signaling NaN
	assign classMask[8] = isNan & ~quietBit;
	assign classMask[9] = isNan & quietBit;

endmodule

`default_nettype wire

// ==== fpuResultQueue.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// result queue
// two-entry in-order buffer, credits returned upstream, spent downstream
////////////////////

module fpuResultQueue (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wrValid,
	input  logic [fpuPkg::FLEN-1:0] wrRes,
	input  logic                    wrInvalid,
	input  logic                    outCredit,
	output logic                    outValid,
	output logic [fpuPkg::FLEN-1:0] outRes,
	output logic                    outInvalid,
	output logic                    inCredit
);

	logic [fpuPkg::FLEN-1:0]                    resMem [fpuPkg::QUEUE_DEPTH];
	logic                                       invMem [fpuPkg::QUEUE_DEPTH];
	logic [$clog2(fpuPkg::QUEUE_DEPTH)-1:0]     wrPtr, rdPtr;
	logic [$clog2(fpuPkg::QUEUE_DEPTH+1)-1:0]   count;
	logic [$clog2(fpuPkg::OUT_CREDITS+1)-1:0]   credits;
	logic                                       issue;

	// issue needs something stored and a credit from downstream
	assign issue      = (count != '0) && (credits != '0);
	assign outValid   = issue;
	assign outRes     = resMem[rdPtr];
	assign outInvalid = invMem[rdPtr];
	// every entry leaving frees one slot for upstream
	assign inCredit   = issue;

	////////////////////
	// storage
	////////////////////

	// upstream credits keep writes from landing on a full queue
	always_ff @(posedge clk) begin
		if (wrValid) begin
			resMem[wrPtr] <= wrRes;
			invMem[wrPtr] <= wrInvalid;
		end
	end

	////////////////////
	// pointers and counts
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			credits <= ($clog2(fpuPkg::OUT_CREDITS+1))'(fpuPkg::OUT_CREDITS);
		end else begin
			// the pointers wrap on their own at depth two
			if (wrValid) wrPtr <= wrPtr + 1'b1;
			if (issue) rdPtr <= rdPtr + 1'b1;
			case ({wrValid, issue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// a returned credit and a spent one in one cycle cancel out
			case ({outCredit, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== fpuSimpleOps.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// fpu simple ops top
// unpacks operands, runs sign-inject, compare and classify, queues the result
////////////////////

module fpuSimpleOps (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inValid,
	input  fpuPkg::fpuOpT           inOp,
	input  fpuPkg::fmtT             inFmt,
	input  logic [fpuPkg::FLEN-1:0] inX,
	input  logic [fpuPkg::FLEN-1:0] inY,
	input  logic                    outCredit,
	output logic                    inCredit,
	output logic                    outValid,
	output logic [fpuPkg::FLEN-1:0] outRes,
	output logic                    outInvalid
);

	logic                       xSgn, xExpZero, xExpMax, xFracZero, xQuietBit;
	logic                       ySgn, yExpZero, yExpMax, yFracZero, yQuietBit;
	logic [fpuPkg::FLEN-1:0]    xFixed, yFixed;
	logic [fpuPkg::FLEN-1:0]    sgnRes, cmpRes, selRes;
	logic [fpuPkg::CLASS_W-1:0] classMask;
	logic                       cmpInvalid, selInvalid;

	////////////////////
	// operand unpack
	////////////////////

	fpuUnpack xUnpack (
		.val(inX), .fmt(inFmt), .sgn(xSgn), .expZero(xExpZero), .expMax(xExpMax),
		.fracZero(xFracZero), .quietBit(xQuietBit), .fixed(xFixed)
	);

	fpuUnpack yUnpack (
		.val(inY), .fmt(inFmt), .sgn(ySgn), .expZero(yExpZero), .expMax(yExpMax),
		.fracZero(yFracZero), .quietBit(yQuietBit), .fixed(yFixed)
	);

	////////////////////
	// compute blocks
	////////////////////

	// the sign-injection opcodes are 0..2 so the low bits are the select
	fpuSignInject signInject (
		.xSgn(xSgn), .ySgn(ySgn), .srcX(xFixed), .fmt(inFmt),
		.sgnOp(inOp[1:0]), .sgnRes(sgnRes)
	);

	fpuCompare compare (
		.fmt(inFmt), .op(inOp), .srcX(xFixed), .srcY(yFixed),
		.xSgn(xSgn), .xExpMax(xExpMax), .xFracZero(xFracZero),
		.xQuietBit(xQuietBit), .xExpZero(xExpZero),
		.ySgn(ySgn), .yExpMax(yExpMax), .yFracZero(yFracZero),
		.yQuietBit(yQuietBit), .yExpZero(yExpZero),
		.cmpRes(cmpRes), .invalid(cmpInvalid)
	);

	// fclass looks at X only
	fpuClassify classify (
		.sgn(xSgn), .expZero(xExpZero), .expMax(xExpMax), .fracZero(xFracZero),
		.quietBit(xQuietBit), .classMask(classMask)
	);

	// compare results already arrive zero-extended into the selected result
	always_comb begin
		selRes     = '0;
		selInvalid = 1'b0;
		case (inOp)
			fpuPkg::OP_FSGNJ, fpuPkg::OP_FSGNJN, fpuPkg::OP_FSGNJX: begin
				selRes = sgnRes;
			end
			fpuPkg::OP_FMIN, fpuPkg::OP_FMAX, fpuPkg::OP_FEQ,
			fpuPkg::OP_FLT, fpuPkg::OP_FLE: begin
				selRes     = cmpRes;
				selInvalid = cmpInvalid;
			end
			fpuPkg::OP_FCLASS: begin
				selRes = {{(fpuPkg::FLEN-fpuPkg::CLASS_W){1'b0}}, classMask};
			end
			default: begin
				selRes     = '0;
				selInvalid = 1'b0;
			end
		endcase
	end

	// results wait here until downstream has a credit
	fpuResultQueue resultQueue (
		.clk(clk), .rst(rst), .wrValid(inValid), .wrRes(selRes),
		.wrInvalid(selInvalid), .outCredit(outCredit), .outValid(outValid),
		.outRes(outRes), .outInvalid(outInvalid), .inCredit(inCredit)
	);

endmodule

`default_nettype wire

// ==== fpuSimpleOpsTb.sv ====
`default_nettype none
`timescale 1ns/100ps
////////////////////
// fpu simple ops testbench
// reference model, credit driver and result scoreboard
////////////////////

module fpuSimpleOpsTb;

	localparam int WAIT_LIMIT = 400;
	localparam int WINDOW = 20;

	// index 10 holds a badly boxed single and a negative qNaN double
	localparam logic [63:0] D_SPECIAL [0:10] = '{
		64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h7ff0_0000_0000_0000,
		64'hfff0_0000_0000_0000, 64'h7ff8_0000_0000_0000, 64'h7ff0_0000_0000_0001,
		64'h0000_0000_0000_0001, 64'h800f_ffff_ffff_ffff, 64'h3ff0_0000_0000_0000,
		64'hbff0_0000_0000_0000, 64'hfff8_0000_0000_0000};
	localparam logic [63:0] S_SPECIAL [0:10] = '{
		64'hffff_ffff_0000_0000, 64'hffff_ffff_8000_0000, 64'hffff_ffff_7f80_0000,
		64'hffff_ffff_ff80_0000, 64'hffff_ffff_7fc0_0000, 64'hffff_ffff_7f80_0001,
		64'hffff_ffff_0000_0001, 64'hffff_ffff_807f_ffff, 64'hffff_ffff_3f80_0000,
		64'hffff_ffff_bf80_0000, 64'h0000_0000_3f80_0000};

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 inValid;
	fpuPkg::fpuOpT        inOp;
	fpuPkg::fmtT          inFmt;
	logic [63:0]          inX, inY;
	logic                 outCredit = 1'b0;
	logic                 inCredit, outValid, outInvalid;
	logic [63:0]          outRes;

	int                   seed = 89;
	logic                 returnEn, extraGrant;
	int                   upCredits = 0;
	int                   upAvail;
	int                   issuedCount = 0;
	int                   resultCount = 0;
	int                   creditPulses = 0;
	int                   checkCount = 0;
	int                   errCount = 0;
	int                   flowErr = 0;
	logic [64:0]          expQ [$];
	string                nameQ [$];
	fpuPkg::fpuOpT        opQ [$];
	logic [64:0]          headExp;
	string                headName;
	fpuPkg::fpuOpT        headOp;

	always #2 clk = ~clk;

	fpuSimpleOps fpuSimpleOps_inst (
		.clk(clk), .rst(rst), .inValid(inValid), .inOp(inOp), .inFmt(inFmt),
		.inX(inX), .inY(inY), .outCredit(outCredit), .inCredit(inCredit),
		.outValid(outValid), .outRes(outRes), .outInvalid(outInvalid)
	);

	////////////////////
	// reference model
	////////////////////

	// a single counts only when all upper bits are ones and is the canonical NaN otherwise
	function automatic logic [63:0] boxFix(input fpuPkg::fmtT fmt, input logic [63:0] v);
		if (fmt == fpuPkg::FMT_S && v[63:32] != 32'hffff_ffff)
			return 64'hffff_ffff_7fc0_0000;
		return v;
	endfunction

	// index of the fclass bit for a corrected operand
	function automatic int classOf(input fpuPkg::fmtT fmt, input logic [63:0] v);
		logic s, eOnes, eZeros, fZero, quiet;
		if (fmt == fpuPkg::FMT_D) begin
			s = v[63];
			eOnes = (v[62:52] == 11'h7ff);
			eZeros = (v[62:52] == 11'h000);
			fZero = (v[51:0] == 52'd0);
			quiet = v[51];
		end else begin
			s = v[31];
			eOnes = (v[30:23] == 8'hff);
			eZeros = (v[30:23] == 8'h00);
			fZero = (v[22:0] == 23'd0);
			quiet = v[22];
		end
		if (eOnes && !fZero) return quiet ? 9 : 8;
		if (eOnes) return s ? 0 : 7;
		if (eZeros && fZero) return s ? 3 : 4;
		if (eZeros) return s ? 2 : 5;
		return s ? 1 : 6;
	endfunction

	// signed ordering key where both zeros map to the same key
	function automatic longint keyOf(input fpuPkg::fmtT fmt, input logic [63:0] v);
		longint mag;
		logic s;
		mag = (fmt == fpuPkg::FMT_D) ? longint'({1'b0, v[62:0]}) : longint'({33'd0, v[30:0]});
		s = (fmt == fpuPkg::FMT_D) ? v[63] : v[31];
		return s ? -mag : mag;
	endfunction

	// expected {invalid, result} straight from the instruction rules
	function automatic logic [64:0] expectedOf(input fpuPkg::fpuOpT op,
			input fpuPkg::fmtT fmt, input logic [63:0] x, input logic [63:0] y);
		logic [63:0] xv, yv, res, canon;
		logic        xs, ys, ns, inv, xNan, yNan, anySig;
		longint      kx, ky;
		xv = boxFix(fmt, x);
		yv = boxFix(fmt, y);
		xs = (fmt == fpuPkg::FMT_D) ? xv[63] : xv[31];
		ys = (fmt == fpuPkg::FMT_D) ? yv[63] : yv[31];
		xNan = classOf(fmt, xv) >= 8;
		yNan = classOf(fmt, yv) >= 8;
		anySig = (classOf(fmt, xv) == 8) || (classOf(fmt, yv) == 8);
		kx = keyOf(fmt, xv);
		ky = keyOf(fmt, yv);
		canon = (fmt == fpuPkg::FMT_D) ? 64'h7ff8_0000_0000_0000 : 64'hffff_ffff_7fc0_0000;
		res = 64'd0;
		inv = 1'b0;
		ns = 1'b0;
		case (op)
			fpuPkg::OP_FSGNJ, fpuPkg::OP_FSGNJN, fpuPkg::OP_FSGNJX: begin
				if (op == fpuPkg::OP_FSGNJ) ns = ys;
				else if (op == fpuPkg::OP_FSGNJN) ns = ~ys;
				else ns = xs ^ ys;
				res = (fmt == fpuPkg::FMT_D) ? {ns, xv[62:0]} :
					{32'hffff_ffff, ns, xv[30:0]};
			end
			fpuPkg::OP_FMIN, fpuPkg::OP_FMAX: begin
				inv = anySig;
				if (xNan && yNan) res = canon;
				else if (xNan) res = yv;
				else if (yNan) res = xv;
				else if (kx < ky) res = (op == fpuPkg::OP_FMIN) ? xv : yv;
				else if (ky < kx) res = (op == fpuPkg::OP_FMIN) ? yv : xv;
				// on equal keys min prefers the negative zero and max the positive one
				else res = (xs == (op == fpuPkg::OP_FMIN)) ? xv : yv;
			end
			fpuPkg::OP_FEQ: begin
				res[0] = !xNan && !yNan && (kx == ky);
				inv = anySig;
			end
			fpuPkg::OP_FLT: begin
				res[0] = !xNan && !yNan && (kx < ky);
				inv = xNan || yNan;
			end
			fpuPkg::OP_FLE: begin
				res[0] = !xNan && !yNan && (kx <= ky);
				inv = xNan || yNan;
			end
			default: res = 64'd1 << classOf(fmt, xv);
		endcase
		return {inv, res};
	endfunction

	// about two thirds are specials and the rest are random normals
	function automatic logic [63:0] randOperand(input fpuPkg::fmtT fmt);
		logic [63:0] bits;
		int          idx;
		idx = {$random(seed)} % 16;
		bits = {$random(seed), $random(seed)};
		if (idx < 11) return (fmt == fpuPkg::FMT_D) ? D_SPECIAL[idx] : S_SPECIAL[idx];
		if (fmt == fpuPkg::FMT_D) begin
			bits[62:52] = 11'd1 + 11'({$random(seed)} % 2046);
			return bits;
		end
		bits[63:32] = 32'hffff_ffff;
		bits[30:23] = 8'd1 + 8'({$random(seed)} % 254);
		return bits;
	endfunction

	////////////////////
	// credits and checking
	////////////////////

	// upstream credits after the cycle that ends at this edge
	assign upAvail = upCredits + int'(inCredit) - int'(inValid);

	always @(posedge clk) begin
		if (rst) upCredits <= fpuPkg::QUEUE_DEPTH;
		else upCredits <= upAvail;
	end

	// downstream hands a credit back for each result unless it is holding them
	always @(posedge clk) begin
		if (rst) outCredit <= 1'b0;
		else outCredit <= (returnEn && outValid) || extraGrant;
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (inCredit) creditPulses++;
			if (outValid) begin
				resultCount++;
				if (expQ.size() == 0) begin
					errCount++;
					$display("result %h arrived with no issued op waiting for it", outRes);
				end else begin
					headExp = expQ.pop_front();
					headName = nameQ.pop_front();
					headOp = opQ.pop_front();
					checkCount++;
					assert (outRes == headExp[63:0]) else begin
						errCount++;
						$display("Fail %s result: expected %h, actual %h",
							headName, headExp[63:0], outRes);
					end
					assert (outInvalid == headExp[64]) else begin
						errCount++;
						$display("Fail %s invalid: expected %b, actual %b",
							headName, headExp[64], outInvalid);
					end
					if (headOp == fpuPkg::OP_FCLASS) begin
						assert ($countones(outRes) == 1) else begin
							errCount++;
							$display("fclass mask %h does not have exactly one bit set", outRes);
						end
					end
				end
			end
		end
	end

	////////////////////
	// driver tasks
	////////////////////

	task automatic abortRun(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST FAIL");
		$finish;
	endtask

	// issues one op on the first edge with an upstream credit
	task automatic issueOp(input fpuPkg::fpuOpT op, input fpuPkg::fmtT fmt,
			input logic [63:0] x, input logic [63:0] y, input string name);
		int waited;
		waited = 0;
		@(posedge clk);
		while (upAvail <= 0 && waited < WAIT_LIMIT) begin
			inValid <= 1'b0;
			waited++;
			@(posedge clk);
		end
		if (upAvail <= 0) begin
			abortRun("an upstream credit");
		end else begin
			inValid <= 1'b1;
			inOp <= op;
			inFmt <= fmt;
			inX <= x;
			inY <= y;
			expQ.push_back(expectedOf(op, fmt, x, y));
			nameQ.push_back(name);
			opQ.push_back(op);
			issuedCount++;
		end
	endtask

	task automatic waitResults(input int target);
		int waited;
		waited = 0;
		@(posedge clk);
		inValid <= 1'b0;
		while (resultCount < target && waited < WAIT_LIMIT) begin
			waited++;
			@(posedge clk);
		end
		if (resultCount < target) abortRun("results from the queue");
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		int f, o, i, j, base;
		rst = 1'b1;
		inValid = 1'b0;
		inOp = fpuPkg::OP_FSGNJ;
		inFmt = fpuPkg::FMT_D;
		inX = 64'd0;
		inY = 64'd0;
		returnEn = 1'b1;
		extraGrant = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// sign injection in both formats
		for (f = 0; f < 2; f++)
			for (o = 0; o < 3; o++)
				repeat (8) issueOp(fpuPkg::fpuOpT'(o), fpuPkg::fmtT'(f),
					randOperand(fpuPkg::fmtT'(f)), randOperand(fpuPkg::fmtT'(f)), "sign inject");

		// unboxed singles in X and then Y through every op
		for (o = 0; o < 9; o++) begin
			issueOp(fpuPkg::fpuOpT'(o), fpuPkg::FMT_S, S_SPECIAL[10], S_SPECIAL[8], "nan box x");
			issueOp(fpuPkg::fpuOpT'(o), fpuPkg::FMT_S, S_SPECIAL[9], S_SPECIAL[10], "nan box y");
		end

		// min, max and compares over every special pair, then random pairs
		for (f = 0; f < 2; f++)
			for (o = 3; o < 8; o++) begin
				for (i = 0; i < 11; i++)
					for (j = 0; j < 11; j++)
						issueOp(fpuPkg::fpuOpT'(o), fpuPkg::fmtT'(f),
							(f == 1) ? D_SPECIAL[i] : S_SPECIAL[i],
							(f == 1) ? D_SPECIAL[j] : S_SPECIAL[j], "special pair");
				repeat (40) issueOp(fpuPkg::fpuOpT'(o), fpuPkg::fmtT'(f),
					randOperand(fpuPkg::fmtT'(f)), randOperand(fpuPkg::fmtT'(f)), "random pair");
			end

		// classify each special and some random values
		for (f = 0; f < 2; f++) begin
			for (i = 0; i < 11; i++)
				issueOp(fpuPkg::OP_FCLASS, fpuPkg::fmtT'(f),
					(f == 1) ? D_SPECIAL[i] : S_SPECIAL[i], 64'd0, "fclass special");
			repeat (20) issueOp(fpuPkg::OP_FCLASS, fpuPkg::fmtT'(f),
				randOperand(fpuPkg::fmtT'(f)), 64'd0, "fclass random");
		end

		// downstream holds its credits back to stall the queue
		waitResults(issuedCount);
		repeat (3) @(posedge clk);
		returnEn <= 1'b0;
		base = resultCount;
		for (i = 0; i < fpuPkg::OUT_CREDITS + fpuPkg::QUEUE_DEPTH; i++)
			issueOp(fpuPkg::fpuOpT'(i % 9), fpuPkg::FMT_D, randOperand(fpuPkg::FMT_D),
				randOperand(fpuPkg::FMT_D), "credit flow");
		waitResults(base + fpuPkg::OUT_CREDITS);
		for (i = 0; i < WINDOW; i++) begin
			@(posedge clk);
			assert (!outValid) else begin
				flowErr++;
				$display("Fail credit flow outValid: expected 0, actual %b", outValid);
			end
			assert (upAvail == 0) else begin
				flowErr++;
				$display("Fail credit flow upstream credits: expected 0, actual %0d", upAvail);
			end
		end
		assert (expQ.size() == fpuPkg::QUEUE_DEPTH) else begin
			flowErr++;
			$display("Fail credit flow queued: expected %0d, actual %0d",
				fpuPkg::QUEUE_DEPTH, expQ.size());
		end

		// give back the held credits and let the queue drain in order
		returnEn <= 1'b1;
		extraGrant <= 1'b1;
		repeat (fpuPkg::OUT_CREDITS) @(posedge clk);
		extraGrant <= 1'b0;
		waitResults(issuedCount);
		assert (creditPulses == resultCount) else begin
			flowErr++;
			$display("Fail inCredit pulses: expected %0d, actual %0d", resultCount, creditPulses);
		end

		$display("issued %0d, results %0d, checks %0d, check errors %0d, flow errors %0d",
			issuedCount, resultCount, checkCount, errCount, flowErr);
		if (errCount == 0 && flowErr == 0 && resultCount == issuedCount) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
fpuPkg.sv
fpuUnpack.sv
fpuSignInject.sv
fpuCompare.sv
fpuClassify.sv
fpuResultQueue.sv
fpuSimpleOps.sv
fpuSimpleOpsTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fpu simple ops testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpuSimpleOpsTb -f files.f -o simv

./obj_dir/simv | tee sim.log

# the run passes only if the log holds the pass line
grep -q "^TEST PASS$" sim.log
echo "simulation passed"
